// File: hdl/loader_settings.svh
/*
 * Loader settings
 * Memory width, file-type indices, load bases and the CRT header layout
 * used along the media download path
 */
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// ========================================
// Memory
// ========================================
`define LDR_ADDR_W          25
`define LDR_CRT_BASE        25'h100000
`define LDR_TAP_BASE        25'h200000
// 8 KB bank alignment for cartridge chips
`define LDR_BANK_ALIGN_BITS 13
// Cycle-phase code of the free memory slot
`define LDR_SLOT_CES        4'b1011

// ========================================
// Host file-type indices
// ========================================
`define LDR_IDX_PRG         8'd4
`define LDR_IDX_CRT         8'd5
`define LDR_IDX_CRT_ALT     8'hC0
`define LDR_IDX_TAP         8'd6

// ========================================
// CRT image layout
// ========================================
`define LDR_CRT_CHIP_START  25'h40
// Cartridge id is big endian, two bytes
`define LDR_CRT_ID_OFS      25'h16
`define LDR_CRT_EXROM_OFS   25'h18
`define LDR_CRT_GAME_OFS    25'h19
`define LDR_CHIP_HDR_LEN    16

`endif

// File: hdl/loader_pkg.sv
/*
 * Loader package
 * Address, byte and cartridge descriptor types shared by the
 * download path, plus the CRT index check
 */
`default_nettype none

`include "loader_settings.svh"

package loader_pkg;

	typedef logic [`LDR_ADDR_W-1:0] mem_addr_t;
	typedef logic [7:0] byte_t;

	// How the sequencer treats one byte of a CRT image
	typedef enum logic [1:0] {
		BK_SKIP,
		BK_ALIGN,
		BK_PAYLOAD
	} byte_kind_e;

	// Bank descriptor taken from a CHIP packet header
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] bank_laddr;
		logic [15:0] bank_size;
	} cart_bank_t;

	// Fields of the CRT file header
	typedef struct packed {
		logic [15:0] cart_id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	// Both cartridge indices lead to the same parser
	function automatic logic is_crt_index(input byte_t idx);
		return (idx == `LDR_IDX_CRT) || (idx == `LDR_IDX_CRT_ALT);
	endfunction

endpackage

`default_nettype wire

// File: hdl/ioctl_if.sv
/*
 * Host download stream
 * One byte per write strobe, tagged with its file offset and the
 * file-type index of the running download
 */
`default_nettype none
`timescale 1ns/100ps

interface ioctl_if;
	import loader_pkg::*;

	// Level, high for the whole download
	logic      download;
	byte_t     index;
	// One-cycle strobe per byte
	logic      wr;
	mem_addr_t addr;
	byte_t     data;

	modport sink (
		input download,
		input index,
		input wr,
		input addr,
		input data
	);

endinterface

`default_nettype wire

// File: hdl/mem_port_if.sv
/*
 * Byte-wide memory request
 * Enable, write, address and data of one request toward the memory port
 */
`default_nettype none
`timescale 1ns/100ps

interface mem_port_if;
	import loader_pkg::*;

	logic      ce;
	logic      we;
	mem_addr_t addr;
	byte_t     data;

	modport issuer (
		output ce,
		output we,
		output addr,
		output data
	);

	modport receiver (
		input ce,
		input we,
		input addr,
		input data
	);

endinterface

`default_nettype wire

// File: hdl/crt_chip_parser.sv
/*
 * CRT chip parser
 * Picks cartridge id, EXROM and GAME out of the CRT file header, walks
 * the CHIP packet headers and strobes out each bank descriptor.
 * Every byte is classed as header, align point or payload.
 */
`default_nettype none
`timescale 1ns/100ps

`include "loader_settings.svh"

module crt_chip_parser (
	input  wire                    clk_sys,
	input  wire                    reset_n,
	ioctl_if.sink                  ioctl,
	output loader_pkg::cart_info_t info_o,
	output loader_pkg::cart_bank_t bank_o,
	output logic                   bank_wr_o,
	output loader_pkg::byte_kind_e kind_o
);
	import loader_pkg::*;

	localparam int hdr_cnt_w = $clog2(`LDR_CHIP_HDR_LEN);
	localparam logic [hdr_cnt_w-1:0] hdr_last = hdr_cnt_w'(`LDR_CHIP_HDR_LEN - 1);

	logic                 crt_wr;
	logic                 in_chips;
	logic                 in_hdr;
	logic [hdr_cnt_w-1:0] hdr_cnt;
	// Remaining payload bytes of the current CHIP packet
	logic [31:0]          blk_len;

	assign crt_wr   = ioctl.wr && is_crt_index(ioctl.index);
	assign in_chips = (ioctl.addr >= `LDR_CRT_CHIP_START);
	assign in_hdr   = in_chips && (hdr_cnt != '0);

	// Class of the byte now on the stream
	always_comb begin
		if (!in_chips || in_hdr)
			kind_o = BK_SKIP;
		else if (blk_len == '0)
			kind_o = BK_ALIGN;
		else
			kind_o = BK_PAYLOAD;
	end

	// ========================================
	// Packet walk
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt   <= '0;
			blk_len   <= '0;
			bank_wr_o <= 1'b0;
		end else begin
			bank_wr_o <= 1'b0;
			if (crt_wr) begin
				if (ioctl.addr == '0) begin
					hdr_cnt <= '0;
					blk_len <= '0;
				end else if (kind_o == BK_ALIGN) begin
					hdr_cnt <= hdr_cnt_w'(1);
				end else if (kind_o == BK_PAYLOAD) begin
					blk_len <= blk_len - 32'd1;
				end else if (in_hdr) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4: blk_len[31:24] <= ioctl.data;
						5: blk_len[23:16] <= ioctl.data;
						6: blk_len[15:8]  <= ioctl.data;
						7: blk_len[7:0]   <= ioctl.data;
						// Packet length counts the header too
						8: blk_len <= blk_len - 32'(`LDR_CHIP_HDR_LEN);
						hdr_last: bank_wr_o <= 1'b1;
						default: ;
					endcase
				end
			end
		end
	end

	// Header fields, big endian
	always_ff @(posedge clk_sys) begin
		if (crt_wr) begin
			case (ioctl.addr)
				`LDR_CRT_ID_OFS:     info_o.cart_id[15:8] <= ioctl.data;
				`LDR_CRT_ID_OFS + 1: info_o.cart_id[7:0]  <= ioctl.data;
				`LDR_CRT_EXROM_OFS:  info_o.exrom         <= ioctl.data;
				`LDR_CRT_GAME_OFS:   info_o.game          <= ioctl.data;
				default: ;
			endcase
		end
		if (crt_wr && in_hdr) begin
			case (hdr_cnt)
				// Type is one byte wide, the low byte lands last
				8, 9:     bank_o.bank_type        <= ioctl.data;
				10:       bank_o.bank_num[15:8]   <= ioctl.data;
				11:       bank_o.bank_num[7:0]    <= ioctl.data;
				12:       bank_o.bank_laddr[15:8] <= ioctl.data;
				13:       bank_o.bank_laddr[7:0]  <= ioctl.data;
				14:       bank_o.bank_size[15:8]  <= ioctl.data;
				hdr_last: bank_o.bank_size[7:0]   <= ioctl.data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/download_sequencer.sv
/*
 * Download sequencer
 * Keeps the load address for PRG, CRT and TAP downloads and raises a
 * pending write for every byte that goes to memory.
 * The host is held off while that byte waits for its slot.
 */
`default_nettype none
`timescale 1ns/100ps

`include "loader_settings.svh"

module download_sequencer (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	ioctl_if.sink                       ioctl,
	input  wire loader_pkg::byte_kind_e kind_i,
	input  wire                         take_i,
	mem_port_if.issuer                  wr_req,
	output loader_pkg::mem_addr_t       load_addr_o,
	output logic                        cart_attached_o,
	output logic                        ioctl_wait_o
);
	import loader_pkg::*;

	localparam int align_w = `LDR_BANK_ALIGN_BITS;

	logic      is_prg;
	logic      is_crt;
	logic      is_tap;
	logic      pending;
	logic      old_download;
	byte_t     data_q;
	mem_addr_t bank_next;

	assign is_prg = (ioctl.index == `LDR_IDX_PRG);
	assign is_crt = is_crt_index(ioctl.index);
	assign is_tap = (ioctl.index == `LDR_IDX_TAP);

	// Start of the next 8 KB bank
	assign bank_next = {load_addr_o[$bits(mem_addr_t)-1:align_w] + 1'b1, {align_w{1'b0}}};

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending         <= 1'b0;
			load_addr_o     <= '0;
			old_download    <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			old_download <= ioctl.download;
			if (take_i) begin
				pending     <= 1'b0;
				load_addr_o <= load_addr_o + 1'b1;
			end
			if (ioctl.wr) begin
				// PRG carries its load address in the first two bytes
				if (is_prg) begin
					if (ioctl.addr == '0)
						load_addr_o <= mem_addr_t'(ioctl.data);
					else if (ioctl.addr == mem_addr_t'(1))
						load_addr_o[15:8] <= ioctl.data;
					else
						pending <= 1'b1;
				end
				if (is_crt) begin
					if (ioctl.addr == '0)
						load_addr_o <= `LDR_CRT_BASE;
					if (kind_i == BK_ALIGN && load_addr_o[align_w-1:0] != '0)
						load_addr_o <= bank_next;
					if (kind_i == BK_PAYLOAD)
						pending <= 1'b1;
				end
				if (is_tap) begin
					if (ioctl.addr == '0)
						load_addr_o <= `LDR_TAP_BASE;
					pending <= 1'b1;
				end
			end
			// Cartridge counts as attached once its download has finished
			if (is_crt && old_download != ioctl.download)
				cart_attached_o <= old_download;
		end
	end

	// Host holds its byte steady only until the next strobe
	always_ff @(posedge clk_sys) begin
		if (ioctl.wr)
			data_q <= ioctl.data;
	end

	assign ioctl_wait_o = pending;
	assign wr_req.ce    = pending;
	assign wr_req.we    = 1'b1;
	assign wr_req.addr  = load_addr_o;
	assign wr_req.data  = data_q;

	// Host must not strobe while wait is up, the pending byte would be lost
	assert property (@(posedge clk_sys) disable iff (!reset_n) ioctl.wr |-> !pending)
		else $error("ioctl byte arrived while a write was pending");

endmodule

`default_nettype wire

// File: hdl/slot_writer.sv
/*
 * Slot writer
 * Takes a pending loader write at the end of the free memory slot and
 * puts it on the memory port in the first cycle of the next slot.
 * Outside the slot the core request passes straight through.
 */
`default_nettype none
`timescale 1ns/100ps

`include "loader_settings.svh"

module slot_writer (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire [3:0]             slot_ces_i,
	mem_port_if.receiver          wr_req,
	mem_port_if.receiver          core,
	output logic                  take_o,
	output logic                  mem_ce_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o
);
	import loader_pkg::*;

	logic      slot;
	logic      slot_d;
	logic      slot_end;
	logic      lat_ce;
	mem_addr_t lat_addr;
	byte_t     lat_data;

	assign slot     = (slot_ces_i == `LDR_SLOT_CES);
	assign slot_end = slot_d & ~slot;
	assign take_o   = slot_end & wr_req.ce;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d <= 1'b0;
			lat_ce <= 1'b0;
		end else begin
			slot_d <= slot;
			if (slot_end)
				lat_ce <= wr_req.ce;
			else if (slot)
				lat_ce <= 1'b0;  // write only lives in the first slot cycle
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take_o) begin
			lat_addr <= wr_req.addr;
			lat_data <= wr_req.data;
		end
	end

	// ========================================
	// Memory port mux
	// ========================================
	always_comb begin
		if (slot) begin
			mem_ce_o   = lat_ce;
			mem_we_o   = lat_ce;
			mem_addr_o = lat_addr;
			mem_data_o = lat_data;
		end else begin
			mem_ce_o   = core.ce;
			mem_we_o   = core.we;
			mem_addr_o = core.addr;
			mem_data_o = core.data;
		end
	end

	// Memory port stays idle for the rest of the slot
	assert property (@(posedge clk_sys) disable iff (!reset_n) (slot && slot_d) |-> !mem_ce_o)
		else $error("loader write outside the first slot cycle");

endmodule

`default_nettype wire

// File: hdl/c64_loader_top.sv
/*
 * Media download loader
 * Places PRG, CRT and TAP downloads into external memory through the
 * free memory slot and reports the cartridge header and banks
 */
`default_nettype none
`timescale 1ns/100ps

module c64_loader_top (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	input  wire                        ioctl_download_i,
	input  wire loader_pkg::byte_t     ioctl_index_i,
	input  wire                        ioctl_wr_i,
	input  wire loader_pkg::mem_addr_t ioctl_addr_i,
	input  wire loader_pkg::byte_t     ioctl_data_i,
	output logic                       ioctl_wait_o,
	input  wire [3:0]                  slot_ces_i,
	input  wire                        cpu_ce_i,
	input  wire                        cpu_we_i,
	input  wire loader_pkg::mem_addr_t cpu_addr_i,
	input  wire loader_pkg::byte_t     cpu_data_i,
	output logic                       mem_ce_o,
	output logic                       mem_we_o,
	output loader_pkg::mem_addr_t      mem_addr_o,
	output loader_pkg::byte_t          mem_data_o,
	output logic [15:0]                cart_id_o,
	output logic [7:0]                 cart_exrom_o,
	output logic [7:0]                 cart_game_o,
	output logic                       bank_wr_o,
	output logic [7:0]                 bank_type_o,
	output logic [15:0]                bank_num_o,
	output logic [15:0]                bank_laddr_o,
	output logic [15:0]                bank_size_o,
	output loader_pkg::mem_addr_t      bank_raddr_o,
	output logic                       cart_attached_o
);
	import loader_pkg::*;

	cart_info_t info;
	cart_bank_t bank;
	byte_kind_e kind;
	logic       take;
	mem_addr_t  load_addr;

	ioctl_if    ioctl_bus ();
	mem_port_if wr_req_bus ();
	mem_port_if core_bus ();

	assign ioctl_bus.download = ioctl_download_i;
	assign ioctl_bus.index    = ioctl_index_i;
	assign ioctl_bus.wr       = ioctl_wr_i;
	assign ioctl_bus.addr     = ioctl_addr_i;
	assign ioctl_bus.data     = ioctl_data_i;

	assign core_bus.ce   = cpu_ce_i;
	assign core_bus.we   = cpu_we_i;
	assign core_bus.addr = cpu_addr_i;
	assign core_bus.data = cpu_data_i;

	crt_chip_parser u_parser (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.ioctl     (ioctl_bus),
		.info_o    (info),
		.bank_o    (bank),
		.bank_wr_o (bank_wr_o),
		.kind_o    (kind)
	);

	download_sequencer u_sequencer (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl           (ioctl_bus),
		.kind_i          (kind),
		.take_i          (take),
		.wr_req          (wr_req_bus),
		.load_addr_o     (load_addr),
		.cart_attached_o (cart_attached_o),
		.ioctl_wait_o    (ioctl_wait_o)
	);

	slot_writer u_slot_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.slot_ces_i (slot_ces_i),
		.wr_req     (wr_req_bus),
		.core       (core_bus),
		.take_o     (take),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	assign cart_id_o    = info.cart_id;
	assign cart_exrom_o = info.exrom;
	assign cart_game_o  = info.game;
	assign bank_type_o  = bank.bank_type;
	assign bank_num_o   = bank.bank_num;
	assign bank_laddr_o = bank.bank_laddr;
	assign bank_size_o  = bank.bank_size;
	// At the strobe the load address already sits on the aligned bank start
	assign bank_raddr_o = load_addr;

endmodule

`default_nettype wire

// File: verif/tb_vectors.svh
/*
 * Download vectors
 * Streams in the order they are sent, with the cartridge fields, the
 * attach state after each stream and the bank descriptors of the CRT
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int n_streams = 3;
localparam int n_bytes   = 128;
localparam int n_banks   = 2;

// Per stream: index, byte count, cartridge id, EXROM, GAME, attached after end
localparam byte_t       vec_index    [n_streams] = '{`LDR_IDX_TAP, `LDR_IDX_CRT, `LDR_IDX_PRG};
localparam int          vec_len      [n_streams] = '{12, 104, 12};
localparam logic [15:0] vec_cart_id  [n_streams] = '{16'h0000, 16'h0A13, 16'h0000};
localparam byte_t       vec_exrom    [n_streams] = '{8'h00, 8'h01, 8'h00};
localparam byte_t       vec_game     [n_streams] = '{8'h00, 8'h00, 8'h00};
localparam logic        vec_attached [n_streams] = '{1'b0, 1'b1, 1'b1};

// Per CHIP: type, bank, load address, size, aligned memory address
localparam byte_t       vec_bank_type  [n_banks] = '{8'h02, 8'h02};
localparam logic [15:0] vec_bank_num   [n_banks] = '{16'h0000, 16'h0001};
localparam logic [15:0] vec_bank_laddr [n_banks] = '{16'h8000, 16'hA000};
localparam logic [15:0] vec_bank_size  [n_banks] = '{16'h0005, 16'h0003};
localparam mem_addr_t   vec_bank_raddr [n_banks] = '{25'h100000, 25'h102000};

localparam byte_t vec_bytes [n_bytes] = '{
	// TAP signature
	8'h43, 8'h36, 8'h34, 8'h2D, 8'h54, 8'h41, 8'h50, 8'h45,
	8'h2D, 8'h52, 8'h41, 8'h57,
	// CRT file header, id 0A13, EXROM 1, GAME 0
	8'h43, 8'h36, 8'h34, 8'h20, 8'h43, 8'h41, 8'h52, 8'h54,
	8'h52, 8'h49, 8'h44, 8'h47, 8'h45, 8'h20, 8'h20, 8'h20,
	8'h00, 8'h00, 8'h00, 8'h40, 8'h01, 8'h00, 8'h0A, 8'h13,
	8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h54, 8'h45, 8'h53, 8'h54, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
	// CHIP 0, packet length 21, five payload bytes
	8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, 8'h00, 8'h15,
	8'h00, 8'h02, 8'h00, 8'h00, 8'h80, 8'h00, 8'h00, 8'h05,
	8'hA1, 8'hA2, 8'hA3, 8'hA4, 8'hA5,
	// CHIP 1, packet length 19, starts unaligned
	8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, 8'h00, 8'h13,
	8'h00, 8'h02, 8'h00, 8'h01, 8'hA0, 8'h00, 8'h00, 8'h03,
	8'hB1, 8'hB2, 8'hB3,
	// PRG loading at 0801
	8'h01, 8'h08, 8'h0B, 8'h08, 8'h0A, 8'h00, 8'h9E, 8'h32,
	8'h30, 8'h36, 8'h31, 8'h00
};

`endif

// File: verif/tb_c64_loader.sv
/*
 * Testbench for the media download loader
 * Streams the vector table through the host port, checks each loader
 * write against a reference model, and checks bank strobes, cartridge
 * fields and the core pass-through outside the slot
 */
`default_nettype none
`timescale 1ns/100ps

`include "loader_settings.svh"

module tb_c64_loader;
	import loader_pkg::*;

	`include "tb_vectors.svh"

	localparam int clk_period   = 20;
	localparam int reset_cycles = 16;
	// Slot spacing and host pauses, in clock cycles
	localparam int gap_max      = 6;
	localparam int slot_max     = 2;
	localparam int host_gap_max = 3;
	localparam int byte_cycles  = 2 * (gap_max + slot_max) + host_gap_max + 6;
	localparam int limit_cycles = reset_cycles + n_bytes * byte_cycles
		+ n_streams * (gap_max + slot_max + 20) + 100;
	localparam mem_addr_t bank_mask = mem_addr_t'((1 << `LDR_BANK_ALIGN_BITS) - 1);

	logic        clk_sys;
	logic        reset_n;
	logic        ioctl_download_i;
	byte_t       ioctl_index_i;
	logic        ioctl_wr_i;
	mem_addr_t   ioctl_addr_i;
	byte_t       ioctl_data_i;
	logic        ioctl_wait_o;
	logic [3:0]  slot_ces_i;
	logic        cpu_ce_i;
	logic        cpu_we_i;
	mem_addr_t   cpu_addr_i;
	byte_t       cpu_data_i;
	logic        mem_ce_o;
	logic        mem_we_o;
	mem_addr_t   mem_addr_o;
	byte_t       mem_data_o;
	logic [15:0] cart_id_o;
	logic [7:0]  cart_exrom_o;
	logic [7:0]  cart_game_o;
	logic        bank_wr_o;
	logic [7:0]  bank_type_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;
	mem_addr_t   bank_raddr_o;
	logic        cart_attached_o;

	// Expected loader writes, oldest first
	mem_addr_t   exp_addr[$];
	byte_t       exp_data[$];
	int          banks_seen;
	logic        slot_prev;
	// Reference model state
	mem_addr_t   ref_addr;
	int          chip_pos;
	logic [31:0] chip_len;

	c64_loader_top dut_i (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.slot_ces_i       (slot_ces_i),
		.cpu_ce_i         (cpu_ce_i),
		.cpu_we_i         (cpu_we_i),
		.cpu_addr_i       (cpu_addr_i),
		.cpu_data_i       (cpu_data_i),
		.mem_ce_o         (mem_ce_o),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.bank_wr_o        (bank_wr_o),
		.bank_type_o      (bank_type_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o),
		.bank_raddr_o     (bank_raddr_o),
		.cart_attached_o  (cart_attached_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// Checking
	// ========================================
	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic check_bank();
		if (banks_seen >= n_banks) begin
			$display("Error at %0t ns: more bank strobes than CHIP packets", $time);
			abort_run();
		end else begin
			check_value("bank_type_o", bank_type_o, vec_bank_type[banks_seen]);
			check_value("bank_num_o", bank_num_o, vec_bank_num[banks_seen]);
			check_value("bank_laddr_o", bank_laddr_o, vec_bank_laddr[banks_seen]);
			check_value("bank_size_o", bank_size_o, vec_bank_size[banks_seen]);
			check_value("bank_raddr_o", bank_raddr_o, vec_bank_raddr[banks_seen]);
			banks_seen++;
		end
	endtask

	// Loader writes only in the first slot cycle, core request elsewhere
	task automatic watch_memory();
		logic in_slot;
		forever begin
			@(negedge clk_sys);
			in_slot = (slot_ces_i == `LDR_SLOT_CES);
			if (in_slot && mem_ce_o && slot_prev) begin
				$display("Error at %0t ns: loader write after the first slot cycle", $time);
				abort_run();
			end else if (in_slot && mem_ce_o && exp_addr.size() == 0) begin
				$display("Error at %0t ns: loader write with no byte outstanding", $time);
				abort_run();
			end else if (in_slot && mem_ce_o) begin
				check_value("mem_we_o", mem_we_o, 1'b1);
				check_value("mem_addr_o", mem_addr_o, exp_addr.pop_front());
				check_value("mem_data_o", mem_data_o, exp_data.pop_front());
			end else if (!in_slot) begin
				check_value("mem_ce_o", mem_ce_o, cpu_ce_i);
				check_value("mem_we_o", mem_we_o, cpu_we_i);
				check_value("mem_addr_o", mem_addr_o, cpu_addr_i);
				check_value("mem_data_o", mem_data_o, cpu_data_i);
			end
			if (bank_wr_o)
				check_bank();
			slot_prev = in_slot;
		end
	endtask

	// ========================================
	// Reference model
	// ========================================
	task automatic push_write(input byte_t data);
		exp_addr.push_back(ref_addr);
		exp_data.push_back(data);
		ref_addr = ref_addr + 1'b1;
	endtask

	task automatic model_byte(input byte_t index, input int ofs, input byte_t data);
		if (index == `LDR_IDX_PRG) begin
			if (ofs == 0)
				ref_addr = mem_addr_t'(data);
			else if (ofs == 1)
				ref_addr[15:8] = data;
			else
				push_write(data);
		end else if (index == `LDR_IDX_TAP) begin
			if (ofs == 0)
				ref_addr = `LDR_TAP_BASE;
			push_write(data);
		end else if (index == `LDR_IDX_CRT || index == `LDR_IDX_CRT_ALT) begin
			if (ofs == 0) begin
				ref_addr = `LDR_CRT_BASE;
				chip_pos = 0;
			end else if (ofs >= `LDR_CRT_CHIP_START) begin
				// Each packet starts on a bank boundary
				if (chip_pos == 0)
					ref_addr = (ref_addr + bank_mask) & ~bank_mask;
				if (chip_pos >= 4 && chip_pos < 8)
					chip_len = {chip_len[23:0], data};
				if (chip_pos >= `LDR_CHIP_HDR_LEN)
					push_write(data);
				chip_pos++;
				if (chip_pos >= `LDR_CHIP_HDR_LEN && chip_pos == chip_len)
					chip_pos = 0;
			end
		end
	endtask

	// ========================================
	// Stimulus
	// ========================================
	task automatic drive_slots();
		int         left;
		logic       in_slot;
		logic [3:0] code;
		left = 1;
		in_slot = 1'b0;
		forever begin
			@(posedge clk_sys);
			left--;
			if (left == 0) begin
				in_slot = !in_slot;
				if (in_slot)
					left = 1 + int'($urandom % slot_max);
				else
					left = 1 + int'($urandom % gap_max);
			end
			code = 4'($urandom);
			if (in_slot)
				code = `LDR_SLOT_CES;
			else if (code == `LDR_SLOT_CES)
				code = 4'h0;
			slot_ces_i <= code;
			cpu_ce_i   <= 1'($urandom);
			cpu_we_i   <= 1'($urandom);
			cpu_addr_i <= mem_addr_t'($urandom);
			cpu_data_i <= byte_t'($urandom);
		end
	endtask

	// One host byte, sent only while wait is low
	task automatic send_byte(input byte_t index, input int ofs, input byte_t data);
		int gap;
		gap = int'($urandom % (host_gap_max + 1));
		model_byte(index, ofs, data);
		repeat (gap) @(posedge clk_sys);
		@(negedge clk_sys);
		while (ioctl_wait_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= mem_addr_t'(ofs);
		ioctl_data_i <= data;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b0;
	endtask

	task automatic run_stream(input int s, input int first);
		@(posedge clk_sys);
		ioctl_index_i    <= vec_index[s];
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < vec_len[s]; i++)
			send_byte(vec_index[s], i, vec_bytes[first + i]);
		// Last byte still has to reach memory
		@(negedge clk_sys);
		while (exp_addr.size() != 0)
			@(negedge clk_sys);
		check_value("ioctl_wait_o", ioctl_wait_o, 1'b0);
		if (vec_index[s] == `LDR_IDX_CRT || vec_index[s] == `LDR_IDX_CRT_ALT) begin
			check_value("cart_id_o", cart_id_o, vec_cart_id[s]);
			check_value("cart_exrom_o", cart_exrom_o, vec_exrom[s]);
			check_value("cart_game_o", cart_game_o, vec_game[s]);
			check_value("cart_attached_o", cart_attached_o, 1'b0);
		end
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cart_attached_o", cart_attached_o, vec_attached[s]);
	endtask

	initial begin
		int first;
		void'($urandom(6475));
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		slot_ces_i       = 4'h0;
		cpu_ce_i         = 1'b0;
		cpu_we_i         = 1'b0;
		cpu_addr_i       = '0;
		cpu_data_i       = '0;
		banks_seen       = 0;
		slot_prev        = 1'b0;
		ref_addr         = '0;
		chip_pos         = 0;
		chip_len         = '0;
		repeat (reset_cycles) @(posedge clk_sys);
		reset_n <= 1'b1;
		fork
			drive_slots();
			watch_memory();
		join_none
		first = 0;
		for (int s = 0; s < n_streams; s++) begin
			run_stream(s, first);
			first += vec_len[s];
		end
		check_value("bank strobe count", banks_seen, n_banks);
		$display("Everything OK");
		$finish;
	end

	// Watchdog sized from the table length and the widest slot spacing
	initial begin
		#(limit_cycles * clk_period);
		$display("Error at %0t ns: watchdog expired before the streams finished", $time);
		abort_run();
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
+incdir+verif
hdl/loader_pkg.sv
hdl/ioctl_if.sv
hdl/mem_port_if.sv
hdl/crt_chip_parser.sv
hdl/download_sequencer.sv
hdl/slot_writer.sv
hdl/c64_loader_top.sv
verif/tb_c64_loader.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_c64_loader
FILELIST ?= sim.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
